/* source/simd_pkg.sv */
// Shared widths, latencies and encodings for the SIMD execution unit
// Imported by every design module and by the testbench

package simd_pkg;

    localparam int VLEN           = 128;
    localparam int ELEN           = 64;
    localparam int LANES          = VLEN / ELEN;
    localparam int MAX_ELEMS      = VLEN / 8;    // One mask bit per element at SEW 8
    localparam int MAX_LAT        = 3;
    localparam int MUL_LAT_NARROW = 2;
    localparam int MUL_LAT_WIDE   = 3;

    typedef logic [VLEN-1:0]      vreg_t;
    typedef logic [ELEN-1:0]      elem_t;
    typedef logic [MAX_ELEMS-1:0] vmask_t;
    typedef logic [4:0]           reg_idx_t;

    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_XOR    = 4'd4,
        OP_MUL    = 4'd5,
        OP_MERGE  = 4'd6,
        OP_MV_S_X = 4'd7,    // Scalar into element 0
        OP_MV_X_S = 4'd8     // Element 0 into scalar
    } simd_op_e;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

    typedef enum logic [1:0] {
        SRC_VV = 2'd0,
        SRC_VX = 2'd1,
        SRC_VI = 2'd2
    } src_sel_e;

    // Cycles since issue of the completing instruction
    typedef enum logic [1:0] {
        AGE_NONE = 2'd0,
        AGE_1    = 2'd1,
        AGE_2    = 2'd2,
        AGE_3    = 2'd3
    } age_e;

endpackage

/* source/simd_ctrl.sv */
// Completion tracking for the SIMD unit
// One valid/metadata shift path per latency; the matured tail is reported
// as an age that steers the lane and merge delay chains

`timescale 1ns/1ps

module simd_ctrl (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               valid_i,
    input  simd_pkg::simd_op_e op_i,
    input  simd_pkg::sew_e     sew_i,
    input  logic               use_mask_i,
    input  simd_pkg::reg_idx_t vd_i,
    input  simd_pkg::reg_idx_t rd_i,
    output simd_pkg::age_e     sel_age_o,
    output simd_pkg::simd_op_e out_op_o,
    output simd_pkg::sew_e     out_sew_o,
    output logic               out_use_mask_o,
    output simd_pkg::reg_idx_t vd_o,
    output simd_pkg::reg_idx_t rd_o,
    output logic               vec_valid_o,
    output logic               scalar_valid_o
);

    import simd_pkg::*;

    age_e               issue_age;              // Latency of the incoming instruction
    logic [MAX_LAT:1]   tail_vld;
    simd_op_e           tail_op   [MAX_LAT:1];
    sew_e               tail_sew  [MAX_LAT:1];
    logic [MAX_LAT:1]   tail_mask;
    reg_idx_t           tail_vd   [MAX_LAT:1];
    reg_idx_t           tail_rd   [MAX_LAT:1];

    always_comb begin
        if (op_i == OP_MUL) begin
            issue_age = (sew_i == SEW_64) ? age_e'(MUL_LAT_WIDE) : age_e'(MUL_LAT_NARROW);
        end else begin
            issue_age = AGE_1;
        end
    end

    // Path p is p registers deep, so its tail matures p edges after issue
    for (genvar p = 1; p <= MAX_LAT; p++) begin : gen_path
        logic     vld_q  [p];
        simd_op_e op_q   [p];
        sew_e     sew_q  [p];
        logic     mask_q [p];
        reg_idx_t vd_q   [p];
        reg_idx_t rd_q   [p];

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                for (int s = 0; s < p; s++) begin
                    vld_q[s] <= 1'b0;
                end
            end else begin
                vld_q[0] <= valid_i && (issue_age == age_e'(p));
                for (int s = 1; s < p; s++) begin
                    vld_q[s] <= vld_q[s-1];
                end
            end
        end

        always_ff @(posedge clk_i) begin
            op_q[0]   <= op_i;
            sew_q[0]  <= sew_i;
            mask_q[0] <= use_mask_i;
            vd_q[0]   <= vd_i;
            rd_q[0]   <= rd_i;
            for (int s = 1; s < p; s++) begin
                op_q[s]   <= op_q[s-1];
                sew_q[s]  <= sew_q[s-1];
                mask_q[s] <= mask_q[s-1];
                vd_q[s]   <= vd_q[s-1];
                rd_q[s]   <= rd_q[s-1];
            end
        end

        assign tail_vld[p]  = vld_q[p-1];
        assign tail_op[p]   = op_q[p-1];
        assign tail_sew[p]  = sew_q[p-1];
        assign tail_mask[p] = mask_q[p-1];
        assign tail_vd[p]   = vd_q[p-1];
        assign tail_rd[p]   = rd_q[p-1];
    end

    // Oldest path wins if more than one tail matures
    always_comb begin
        sel_age_o      = AGE_NONE;
        out_op_o       = tail_op[1];
        out_sew_o      = tail_sew[1];
        out_use_mask_o = tail_mask[1];
        vd_o           = tail_vd[1];
        rd_o           = tail_rd[1];
        for (int p = MAX_LAT; p >= 1; p--) begin
            if (tail_vld[p] && (sel_age_o == AGE_NONE)) begin
                sel_age_o      = age_e'(p);
                out_op_o       = tail_op[p];
                out_sew_o      = tail_sew[p];
                out_use_mask_o = tail_mask[p];
                vd_o           = tail_vd[p];
                rd_o           = tail_rd[p];
            end
        end
    end

    assign vec_valid_o    = (sel_age_o != AGE_NONE) && (out_op_o != OP_MV_X_S);
    assign scalar_valid_o = (sel_age_o != AGE_NONE) && (out_op_o == OP_MV_X_S);

endmodule

/* source/operand_prep.sv */
// First-operand builder for the SIMD lanes
// Passes vs1 through, or replicates the scalar or sign-extended immediate
// across every element of the vector at the current SEW

`timescale 1ns/1ps

module operand_prep (
    input  simd_pkg::sew_e     sew_i,
    input  simd_pkg::src_sel_e src_sel_i,
    input  simd_pkg::vreg_t    data_vs1_i,
    input  simd_pkg::elem_t    data_rs1_i,
    input  logic [4:0]         imm_i,
    output simd_pkg::vreg_t    op1_o
);

    import simd_pkg::*;

    elem_t scalar;
    vreg_t replicated;

    always_comb begin
        // Immediate is a signed 5-bit value
        if (src_sel_i == SRC_VI) begin
            scalar = {{(ELEN-5){imm_i[4]}}, imm_i};
        end else begin
            scalar = data_rs1_i;
        end

        case (sew_i)
            SEW_8:   replicated = {(VLEN/8){scalar[7:0]}};
            SEW_16:  replicated = {(VLEN/16){scalar[15:0]}};
            SEW_32:  replicated = {(VLEN/32){scalar[31:0]}};
            default: replicated = {(VLEN/64){scalar}};
        endcase
    end

    assign op1_o = (src_sel_i == SRC_VV) ? data_vs1_i : replicated;

endmodule

/* source/simd_lane.sv */
// One 64-bit datapath lane of the SIMD unit
// Computes the element-wise result at the issue edge, then carries it down
// a three-stage chain; sel_age_i picks the stage that is completing

`timescale 1ns/1ps

module simd_lane (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  simd_pkg::simd_op_e op_i,
    input  simd_pkg::sew_e     sew_i,
    input  simd_pkg::elem_t    data_op1_i,
    input  simd_pkg::elem_t    data_vs2_i,
    input  simd_pkg::age_e     sel_age_i,
    output simd_pkg::elem_t    lane_result_o
);

    import simd_pkg::*;

    elem_t alu_res;
    elem_t res_q [MAX_LAT];

    // Operands arrive zero-extended; caller keeps the low SEW bits
    function automatic elem_t elem_alu(simd_op_e op, elem_t vs2, elem_t op1);
        case (op)
            OP_ADD:    elem_alu = vs2 + op1;
            OP_SUB:    elem_alu = vs2 - op1;
            OP_AND:    elem_alu = vs2 & op1;
            OP_OR:     elem_alu = vs2 | op1;
            OP_XOR:    elem_alu = vs2 ^ op1;
            OP_MUL:    elem_alu = vs2 * op1;   // Low half only
            OP_MV_X_S: elem_alu = vs2;
            default:   elem_alu = op1;         // Merge and vmv.s.x
        endcase
    endfunction

    // Each element is computed on its own so carries stop at its edge
    always_comb begin
        alu_res = '0;
        case (sew_i)
            SEW_8: begin
                for (int e = 0; e < ELEN / 8; e++) begin
                    alu_res[e*8 +: 8] = 8'(elem_alu(op_i, ELEN'(data_vs2_i[e*8 +: 8]),
                                                    ELEN'(data_op1_i[e*8 +: 8])));
                end
            end
            SEW_16: begin
                for (int e = 0; e < ELEN / 16; e++) begin
                    alu_res[e*16 +: 16] = 16'(elem_alu(op_i, ELEN'(data_vs2_i[e*16 +: 16]),
                                                       ELEN'(data_op1_i[e*16 +: 16])));
                end
            end
            SEW_32: begin
                for (int e = 0; e < ELEN / 32; e++) begin
                    alu_res[e*32 +: 32] = 32'(elem_alu(op_i, ELEN'(data_vs2_i[e*32 +: 32]),
                                                       ELEN'(data_op1_i[e*32 +: 32])));
                end
            end
            default: begin
                alu_res = elem_alu(op_i, data_vs2_i, data_op1_i);
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < MAX_LAT; s++) begin
                res_q[s] <= '0;
            end
        end else begin
            res_q[0] <= alu_res;
            for (int s = 1; s < MAX_LAT; s++) begin
                res_q[s] <= res_q[s-1];
            end
        end
    end

    always_comb begin
        case (sel_age_i)
            AGE_2:   lane_result_o = res_q[1];
            AGE_3:   lane_result_o = res_q[2];
            default: lane_result_o = res_q[0];
        endcase
    end

endmodule

/* source/result_merge.sv */
// Final result assembly for the SIMD unit
// Delays old vd, vs2 and the mask alongside the lanes, then applies
// masking, merge and the two scalar moves for the completing instruction

`timescale 1ns/1ps

module result_merge (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  simd_pkg::vreg_t    data_vs2_i,
    input  simd_pkg::vreg_t    data_old_vd_i,
    input  simd_pkg::vmask_t   data_vm_i,
    input  simd_pkg::age_e     sel_age_i,
    input  simd_pkg::simd_op_e op_i,
    input  simd_pkg::sew_e     sew_i,
    input  logic               use_mask_i,
    input  simd_pkg::vreg_t    lane_result_i,
    output simd_pkg::vreg_t    vresult_o,
    output simd_pkg::elem_t    result_o
);

    import simd_pkg::*;

    vreg_t  vs2_q [MAX_LAT];
    vreg_t  old_q [MAX_LAT];
    vmask_t vm_q  [MAX_LAT];
    int     sel_idx;
    vreg_t  vs2_d;
    vreg_t  old_d;
    vmask_t vm_d;
    vmask_t elem_en;   // Element takes the lane result
    vreg_t  bit_en;
    vreg_t  alt;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < MAX_LAT; s++) begin
                vs2_q[s] <= '0;
                old_q[s] <= '0;
                vm_q[s]  <= '0;
            end
        end else begin
            vs2_q[0] <= data_vs2_i;
            old_q[0] <= data_old_vd_i;
            vm_q[0]  <= data_vm_i;
            for (int s = 1; s < MAX_LAT; s++) begin
                vs2_q[s] <= vs2_q[s-1];
                old_q[s] <= old_q[s-1];
                vm_q[s]  <= vm_q[s-1];
            end
        end
    end

    assign sel_idx = (sel_age_i == AGE_NONE) ? 0 : int'(sel_age_i) - 1;
    assign vs2_d   = vs2_q[sel_idx];
    assign old_d   = old_q[sel_idx];
    assign vm_d    = vm_q[sel_idx];

    always_comb begin
        for (int i = 0; i < MAX_ELEMS; i++) begin
            case (op_i)
                OP_MV_S_X: elem_en[i] = (i == 0);
                OP_MERGE:  elem_en[i] = vm_d[i];
                default:   elem_en[i] = !use_mask_i || vm_d[i];
            endcase
        end

        // Spread element enables over their SEW bits
        bit_en = '0;
        case (sew_i)
            SEW_8:   for (int i = 0; i < VLEN / 8; i++)  bit_en[i*8 +: 8]   = {8{elem_en[i]}};
            SEW_16:  for (int i = 0; i < VLEN / 16; i++) bit_en[i*16 +: 16] = {16{elem_en[i]}};
            SEW_32:  for (int i = 0; i < VLEN / 32; i++) bit_en[i*32 +: 32] = {32{elem_en[i]}};
            default: for (int i = 0; i < VLEN / 64; i++) bit_en[i*64 +: 64] = {64{elem_en[i]}};
        endcase

        alt       = (op_i == OP_MERGE) ? vs2_d : old_d;   // Merge falls back to vs2
        vresult_o = (lane_result_i & bit_en) | (alt & ~bit_en);
    end

    // vmv.x.s reads element 0 of vs2 sign-extended
    always_comb begin
        case (sew_i)
            SEW_8:   result_o = {{(ELEN-8){vs2_d[7]}}, vs2_d[7:0]};
            SEW_16:  result_o = {{(ELEN-16){vs2_d[15]}}, vs2_d[15:0]};
            SEW_32:  result_o = {{(ELEN-32){vs2_d[31]}}, vs2_d[31:0]};
            default: result_o = vs2_d[ELEN-1:0];
        endcase
    end

endmodule

/* source/simd_unit.sv */
// Top level of the SIMD execution unit
// Accepts one instruction per valid_i strobe and returns vector or scalar
// results after 1 to 3 cycles; the issuer avoids completion collisions

`timescale 1ns/1ps

module simd_unit (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               valid_i,
    input  simd_pkg::simd_op_e op_i,
    input  simd_pkg::sew_e     sew_i,
    input  simd_pkg::src_sel_e src_sel_i,
    input  logic               use_mask_i,
    input  simd_pkg::reg_idx_t vd_i,
    input  simd_pkg::reg_idx_t rd_i,
    input  simd_pkg::vreg_t    data_vs1_i,
    input  simd_pkg::vreg_t    data_vs2_i,
    input  simd_pkg::elem_t    data_rs1_i,
    input  logic [4:0]         imm_i,
    input  simd_pkg::vreg_t    data_old_vd_i,
    input  simd_pkg::vmask_t   data_vm_i,
    output logic               vec_valid_o,
    output logic               scalar_valid_o,
    output simd_pkg::reg_idx_t vd_o,
    output simd_pkg::vreg_t    vresult_o,
    output simd_pkg::reg_idx_t rd_o,
    output simd_pkg::elem_t    result_o
);

    import simd_pkg::*;

    age_e     sel_age;
    simd_op_e out_op;
    sew_e     out_sew;
    logic     out_use_mask;
    vreg_t    op1;
    vreg_t    lane_result;

    simd_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .use_mask_i     (use_mask_i),
        .vd_i           (vd_i),
        .rd_i           (rd_i),
        .sel_age_o      (sel_age),
        .out_op_o       (out_op),
        .out_sew_o      (out_sew),
        .out_use_mask_o (out_use_mask),
        .vd_o           (vd_o),
        .rd_o           (rd_o),
        .vec_valid_o    (vec_valid_o),
        .scalar_valid_o (scalar_valid_o)
    );

    operand_prep u_prep (
        .sew_i      (sew_i),
        .src_sel_i  (src_sel_i),
        .data_vs1_i (data_vs1_i),
        .data_rs1_i (data_rs1_i),
        .imm_i      (imm_i),
        .op1_o      (op1)
    );

    for (genvar l = 0; l < LANES; l++) begin : gen_lane
        simd_lane u_lane (
            .clk_i         (clk_i),
            .rstn_i        (rstn_i),
            .op_i          (op_i),
            .sew_i         (sew_i),
            .data_op1_i    (op1[l*ELEN +: ELEN]),
            .data_vs2_i    (data_vs2_i[l*ELEN +: ELEN]),
            .sel_age_i     (sel_age),
            .lane_result_o (lane_result[l*ELEN +: ELEN])
        );
    end

    result_merge u_merge (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .data_vs2_i    (data_vs2_i),
        .data_old_vd_i (data_old_vd_i),
        .data_vm_i     (data_vm_i),
        .sel_age_i     (sel_age),
        .op_i          (out_op),
        .sew_i         (out_sew),
        .use_mask_i    (out_use_mask),
        .lane_result_i (lane_result),
        .vresult_o     (vresult_o),
        .result_o      (result_o)
    );

endmodule

/* test/simd_assertions.sv */
// Concurrent checks on the SIMD completion tracker
// Attached to simd_ctrl with bind from the testbench top

`timescale 1ns/1ps

module simd_assertions (
    input logic                       clk_i,
    input logic                       rstn_i,
    input logic                       valid_i,
    input simd_pkg::simd_op_e         op_i,
    input simd_pkg::sew_e             sew_i,
    input logic [simd_pkg::MAX_LAT:1] tail_vld_i,
    input simd_pkg::simd_op_e         out_op_i,
    input logic                       vec_valid_i,
    input logic                       scalar_valid_i
);

    import simd_pkg::*;

    // A scalar move completes next cycle on the scalar valid alone
    a_scalar_move: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (valid_i && op_i == OP_MV_X_S) |-> ##1 (scalar_valid_i && !vec_valid_i))
        else $error("scalar move did not raise only the scalar valid");

    // Issuer must keep completions in separate cycles
    a_single_tail: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(tail_vld_i))
        else $error("two tracking paths matured in the same cycle");

    a_mul_narrow: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (valid_i && op_i == OP_MUL && sew_i != SEW_64)
            |-> ##MUL_LAT_NARROW (vec_valid_i && out_op_i == OP_MUL))
        else $error("narrow multiply did not complete after its latency");

    a_mul_wide: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (valid_i && op_i == OP_MUL && sew_i == SEW_64)
            |-> ##MUL_LAT_WIDE (vec_valid_i && out_op_i == OP_MUL))
        else $error("wide multiply did not complete after its latency");

endmodule

/* test/tb_simd_unit.sv */
// Testbench for the SIMD execution unit
// Issues LFSR-driven instructions, predicts each completion with a reference
// model and checks the outputs in the cycle each one is due

`timescale 1ns/1ps

module tb_simd_unit;

    import simd_pkg::*;

    localparam int SB_SIZE    = 8;
    localparam int NUM_CYCLES = 600;

    logic     clk_i;
    logic     rstn_i;
    logic     valid_i;
    simd_op_e op_i;
    sew_e     sew_i;
    src_sel_e src_sel_i;
    logic     use_mask_i;
    reg_idx_t vd_i;
    reg_idx_t rd_i;
    vreg_t    data_vs1_i;
    vreg_t    data_vs2_i;
    elem_t    data_rs1_i;
    logic [4:0] imm_i;
    vreg_t    data_old_vd_i;
    vmask_t   data_vm_i;
    logic     vec_valid_o;
    logic     scalar_valid_o;
    reg_idx_t vd_o;
    vreg_t    vresult_o;
    reg_idx_t rd_o;
    elem_t    result_o;

    // Scoreboard slots indexed by completion cycle modulo SB_SIZE
    int       issued_tag [SB_SIZE];
    int       done_tag   [SB_SIZE];
    logic     exp_scalar [SB_SIZE];
    vreg_t    exp_vres   [SB_SIZE];
    elem_t    exp_sres   [SB_SIZE];
    reg_idx_t exp_reg    [SB_SIZE];
    string    exp_name   [SB_SIZE];
    int       issued_total = 0;
    int       done_total   = 0;
    int       cyc          = 0;
    logic [15:0] lfsr;

    simd_unit uut (.*);

    bind simd_ctrl simd_assertions u_assert (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .tail_vld_i     (tail_vld),
        .out_op_i       (out_op_o),
        .vec_valid_i    (vec_valid_o),
        .scalar_valid_i (scalar_valid_o)
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) cyc <= cyc + 1;

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output vreg_t bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[VLEN-2:0], lfsr[0]};
        end
    endtask

    function automatic int issue_latency(simd_op_e op, sew_e sew);
        if (op != OP_MUL) begin
            return 1;
        end
        return (sew == SEW_64) ? MUL_LAT_WIDE : MUL_LAT_NARROW;
    endfunction

    // Scalar or immediate copied into every element
    function automatic vreg_t build_op1(sew_e sew, src_sel_e src, vreg_t vs1, elem_t rs1,
                                        logic [4:0] imm);
        int    w;
        elem_t s;
        vreg_t wmask;
        vreg_t r;
        if (src == SRC_VV) begin
            return vs1;
        end
        w     = 8 << int'(sew);
        wmask = (vreg_t'(1) << w) - vreg_t'(1);
        s     = (src == SRC_VI) ? elem_t'($signed(imm)) : rs1;
        r     = '0;
        for (int i = 0; i < VLEN / w; i++) begin
            r = r | ((vreg_t'(s) & wmask) << (i * w));
        end
        return r;
    endfunction

    function automatic vreg_t expect_vector(simd_op_e op, sew_e sew, vreg_t op1, vreg_t vs2,
                                            vreg_t old_vd, vmask_t vm, logic use_mask);
        int    w;
        vreg_t wmask;
        vreg_t a;
        vreg_t b;
        vreg_t o;
        vreg_t r;
        vreg_t res;
        w     = 8 << int'(sew);
        wmask = (vreg_t'(1) << w) - vreg_t'(1);
        res   = '0;
        for (int i = 0; i < VLEN / w; i++) begin
            a = (vs2 >> (i * w)) & wmask;
            b = (op1 >> (i * w)) & wmask;
            o = (old_vd >> (i * w)) & wmask;
            case (op)
                OP_ADD:   r = a + b;
                OP_SUB:   r = a - b;
                OP_AND:   r = a & b;
                OP_OR:    r = a | b;
                OP_XOR:   r = a ^ b;
                OP_MUL:   r = a * b;          // Masked down to the low SEW bits
                OP_MERGE: r = vm[i] ? b : a;
                default:  r = (i == 0) ? b : o;
            endcase
            if (use_mask && !vm[i] && op != OP_MERGE && op != OP_MV_S_X) begin
                r = o;
            end
            res = res | ((r & wmask) << (i * w));
        end
        return res;
    endfunction

    function automatic elem_t expect_scalar(sew_e sew, vreg_t vs2);
        int    w;
        vreg_t wmask;
        vreg_t e;
        w     = 8 << int'(sew);
        wmask = (vreg_t'(1) << w) - vreg_t'(1);
        e     = vs2 & wmask;
        if (e[w-1]) begin
            e = e | ~wmask;
        end
        return e[ELEN-1:0];
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(input string name, input vreg_t expected, input vreg_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Draws one instruction, or leaves valid_i low on a gap or a collision
    task automatic issue_random();
        vreg_t bits;
        int    v;
        int    slot;
        take_bits(2, bits);
        if (bits[1:0] == 2'b00) begin
            valid_i = 1'b0;
            return;
        end
        take_bits(4, bits);
        v    = int'(bits[3:0]) % 9;
        op_i = simd_op_e'(v[3:0]);
        take_bits(2, bits);
        sew_i = sew_e'(bits[1:0]);
        slot  = (cyc + issue_latency(op_i, sew_i)) % SB_SIZE;
        if (issued_tag[slot] != done_tag[slot]) begin
            valid_i = 1'b0;
            return;
        end
        take_bits(2, bits);
        v         = int'(bits[1:0]) % 3;
        src_sel_i = (op_i == OP_MV_S_X) ? SRC_VX : src_sel_e'(v[1:0]);
        take_bits(11, bits);
        use_mask_i = bits[10];
        vd_i       = bits[9:5];
        rd_i       = bits[4:0];
        take_bits(VLEN, bits);
        data_vs1_i = bits;
        take_bits(VLEN, bits);
        data_vs2_i = bits;
        take_bits(VLEN, bits);
        data_old_vd_i = bits;
        take_bits(ELEN + 5 + MAX_ELEMS, bits);
        data_rs1_i = bits[ELEN+20:21];
        imm_i      = bits[20:16];
        data_vm_i  = bits[15:0];

        exp_scalar[slot] = (op_i == OP_MV_X_S);
        exp_vres[slot]   = expect_vector(op_i, sew_i,
                                         build_op1(sew_i, src_sel_i, data_vs1_i, data_rs1_i, imm_i),
                                         data_vs2_i, data_old_vd_i, data_vm_i, use_mask_i);
        exp_sres[slot]   = expect_scalar(sew_i, data_vs2_i);
        exp_reg[slot]    = (op_i == OP_MV_X_S) ? rd_i : vd_i;
        exp_name[slot]   = $sformatf("%s %s %s mask%0d", op_i.name(), sew_i.name(),
                                     src_sel_i.name(), use_mask_i);
        issued_tag[slot] = issued_tag[slot] + 1;
        issued_total++;
        valid_i = 1'b1;
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk_i) begin
        int slot;
        slot = cyc % SB_SIZE;
        if (rstn_i && issued_tag[slot] != done_tag[slot]) begin
            check_value({exp_name[slot], " vec_valid"}, vreg_t'(!exp_scalar[slot]),
                        vreg_t'(vec_valid_o));
            check_value({exp_name[slot], " scalar_valid"}, vreg_t'(exp_scalar[slot]),
                        vreg_t'(scalar_valid_o));
            if (exp_scalar[slot]) begin
                check_value({exp_name[slot], " result"}, vreg_t'(exp_sres[slot]),
                            vreg_t'(result_o));
                check_value({exp_name[slot], " rd"}, vreg_t'(exp_reg[slot]), vreg_t'(rd_o));
            end else begin
                check_value({exp_name[slot], " vresult"}, exp_vres[slot], vresult_o);
                check_value({exp_name[slot], " vd"}, vreg_t'(exp_reg[slot]), vreg_t'(vd_o));
            end
            done_tag[slot] = issued_tag[slot];
            done_total++;
        end else begin
            check_value("idle valid outputs", vreg_t'(0),
                        vreg_t'({vec_valid_o, scalar_valid_o}));
        end
    end

    initial begin
        int wait_cycles;
        lfsr          = 16'd4;
        rstn_i        = 1'b0;
        valid_i       = 1'b0;
        op_i          = OP_ADD;
        sew_i         = SEW_8;
        src_sel_i     = SRC_VV;
        use_mask_i    = 1'b0;
        vd_i          = '0;
        rd_i          = '0;
        data_vs1_i    = '0;
        data_vs2_i    = '0;
        data_rs1_i    = '0;
        imm_i         = '0;
        data_old_vd_i = '0;
        data_vm_i     = '0;
        repeat (3) @(posedge clk_i);
        #1 rstn_i = 1'b1;

        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk_i);
            #1;
            issue_random();
        end
        @(posedge clk_i);
        #1 valid_i = 1'b0;

        wait_cycles = 0;
        while (issued_total != done_total && wait_cycles < 10) begin
            @(posedge clk_i);
            wait_cycles++;
        end
        if (issued_total == done_total) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("Timeout: expected completions never arrived");
        end
    end

endmodule

/* src.f */
source/simd_pkg.sv
source/simd_ctrl.sv
source/operand_prep.sv
source/simd_lane.sv
source/result_merge.sv
source/simd_unit.sv
test/simd_assertions.sv
test/tb_simd_unit.sv

/* run.sh */
#!/bin/sh
# Compile and run the SIMD unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_simd_unit -f src.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "Simulation finished without errors" \
    || { echo "Simulation reported errors"; exit 1; }
